// ==== Bender.yml ====
package:
  name: periph

sources:
  - source/periph_pkg.sv
  - source/apb_decoder.sv
  - source/gpio_regs.sv
  - source/gpio_pads.sv
  - source/timer.sv
  - source/periph_top.sv
  - target: test
    files:
      - verif/periph_props.sv
      - verif/periph_tb.sv

// ==== compile.f ====
source/periph_pkg.sv
source/apb_decoder.sv
source/gpio_regs.sv
source/gpio_pads.sv
source/timer.sv
source/periph_top.sv
verif/periph_props.sv
verif/periph_tb.sv

// ==== source/apb_decoder.sv ====
`timescale 1ns/1ps

module apb_decoder (
    input  periph_pkg::apb_req_t apb_i,
    output periph_pkg::apb_rsp_t apb_o,

    output periph_pkg::apb_req_t gpio_req_o,
    input  periph_pkg::apb_rsp_t gpio_rsp_i,

    output periph_pkg::apb_req_t timer_req_o,
    input  periph_pkg::apb_rsp_t timer_rsp_i
);
    import periph_pkg::*;

    logic [3:0] region;
    logic       hit_gpio;
    logic       hit_timer;

    assign region    = apb_i.paddr[11:8];
    assign hit_gpio  = (region == GPIO_BASE);
    assign hit_timer = (region == TIMER_BASE);

    // ------------------------------------------------------------------------
    // request fan-out
    // ------------------------------------------------------------------------
    // everything is copied, psel only reaches the addressed slave
    always_comb begin
        gpio_req_o       = apb_i;
        gpio_req_o.psel  = apb_i.psel & hit_gpio;
        timer_req_o      = apb_i;
        timer_req_o.psel = apb_i.psel & hit_timer;
    end

    // ------------------------------------------------------------------------
    // response mux
    // ------------------------------------------------------------------------
    always_comb begin
        apb_o        = '0;
        apb_o.pready = 1'b1;
        if (hit_gpio) begin
            apb_o = gpio_rsp_i;
        end else if (hit_timer) begin
            apb_o = timer_rsp_i;
        end else begin
            // unmapped region, answered here with zero data
            apb_o.pslverr = apb_i.psel & apb_i.penable;
        end
    end

endmodule

// ==== source/gpio_pads.sv ====
`timescale 1ns/1ps

module gpio_pads #(
    parameter int NUM_PINS = 16
) (
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic [2*NUM_PINS-1:0]   mode_i,
    input  logic [NUM_PINS-1:0]     data_i,

    input  logic [NUM_PINS-1:0]     gpio_i,
    output logic [NUM_PINS-1:0]     gpio_o,
    output logic [NUM_PINS-1:0]     gpio_oe_o,
    output logic [NUM_PINS-1:0]     pin_sync_o
);
    import periph_pkg::*;

    logic [NUM_PINS-1:0] oe;
    logic [NUM_PINS-1:0] sync_q1;
    logic [NUM_PINS-1:0] sync_q2;

    // per-pin enable from the 2-bit mode field
    always_comb begin
        for (int n = 0; n < NUM_PINS; n++) begin
            oe[n] = (pin_mode_e'(mode_i[2*n +: 2]) == PIN_OUTPUT);
        end
    end

    assign gpio_oe_o = oe;
    assign gpio_o    = data_i & oe;

    // two-flop synchronizer for the pin inputs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gpio_i;
            sync_q2 <= sync_q1;
        end
    end

    assign pin_sync_o = sync_q2;

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs #(
    parameter int NUM_PINS = 16
) (
    input  logic                    clk,
    input  logic                    reset_i,

    input  periph_pkg::apb_req_t    apb_i,
    output periph_pkg::apb_rsp_t    apb_o,

    output logic [2*NUM_PINS-1:0]   mode_o,
    output logic [NUM_PINS-1:0]     data_o,
    input  logic [NUM_PINS-1:0]     pin_sync_i
);
    import periph_pkg::*;

    localparam int MODE_W = 2 * NUM_PINS;

    logic [MODE_W-1:0]   mode_q;
    logic [NUM_PINS-1:0] data_q;

    gpio_reg_e   offset;
    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic [31:0] rdata;

    assign offset = gpio_reg_e'(apb_i.paddr[3:0]);
    assign access = apb_i.psel & apb_i.penable;
    assign wr_en  = access & apb_i.pwrite & addr_ok;

    // ------------------------------------------------------------------------
    // offset decode and read mux
    // ------------------------------------------------------------------------
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (offset)
            GPIO_CTRL: rdata[MODE_W-1:0] = mode_q;
            GPIO_DATA: rdata[NUM_PINS-1:0] = data_q;
            GPIO_IN: begin
                rdata[NUM_PINS-1:0] = pin_sync_i;
                // input readback is read-only
                addr_ok = ~apb_i.pwrite;
            end
            default: addr_ok = 1'b0;
        endcase
    end

    always_comb begin
        apb_o.pready  = 1'b1;
        apb_o.prdata  = (access && !apb_i.pwrite && addr_ok) ? rdata : '0;
        apb_o.pslverr = access & ~addr_ok;
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mode_q <= '0;
            data_q <= '0;
        end else if (wr_en) begin
            if (offset == GPIO_CTRL) begin
                mode_q <= apb_i.pwdata[MODE_W-1:0];
            end
            if (offset == GPIO_DATA) begin
                data_q <= apb_i.pwdata[NUM_PINS-1:0];
            end
        end
    end

    assign mode_o = mode_q;
    assign data_o = data_q;

endmodule

// ==== source/periph_pkg.sv ====
package periph_pkg;

    // ------------------------------------------------------------------------
    // apb request and response
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    // region codes held in paddr[11:8]
    localparam logic [3:0] GPIO_BASE  = 4'h0;
    localparam logic [3:0] TIMER_BASE = 4'h1;

    // register offsets taken from paddr[3:0]
    typedef enum logic [3:0] {
        GPIO_CTRL = 4'h0,
        GPIO_DATA = 4'h4,
        GPIO_IN   = 4'h8
    } gpio_reg_e;

    typedef enum logic [3:0] {
        TIMER_CTRL  = 4'h0,
        TIMER_COUNT = 4'h4,
        TIMER_VALUE = 4'h8
    } timer_reg_e;

    // timer ctrl bits
    localparam int TIMER_EN_BIT  = 0;
    localparam int TIMER_IE_BIT  = 1;
    localparam int TIMER_PND_BIT = 2;

    // only PIN_OUTPUT drives the pad
    typedef enum logic [1:0] {
        PIN_INPUT  = 2'b00,
        PIN_OUTPUT = 2'b01,
        PIN_RSVD_A = 2'b10,
        PIN_RSVD_B = 2'b11
    } pin_mode_e;

endpackage

// ==== source/periph_top.sv ====
`timescale 1ns/1ps

module periph_top #(
    parameter int NUM_PINS = 16
) (
    input  logic                 clk,
    input  logic                 reset_i,

    input  periph_pkg::apb_req_t apb_i,
    output periph_pkg::apb_rsp_t apb_o,

    input  logic [NUM_PINS-1:0]  gpio_i,
    output logic [NUM_PINS-1:0]  gpio_o,
    output logic [NUM_PINS-1:0]  gpio_oe_o,

    output logic                 irq_o
);
    import periph_pkg::*;

    apb_req_t gpio_req;
    apb_rsp_t gpio_rsp;
    apb_req_t timer_req;
    apb_rsp_t timer_rsp;

    logic [2*NUM_PINS-1:0] gpio_mode;
    logic [NUM_PINS-1:0]   gpio_data;
    logic [NUM_PINS-1:0]   gpio_sync;

    // ------------------------------------------------------------------------
    // bus decode
    // ------------------------------------------------------------------------
    apb_decoder i_apb_decoder (
        .apb_i          ( apb_i         ),
        .apb_o          ( apb_o         ),
        .gpio_req_o     ( gpio_req      ),
        .gpio_rsp_i     ( gpio_rsp      ),
        .timer_req_o    ( timer_req     ),
        .timer_rsp_i    ( timer_rsp     )
    );

    // ------------------------------------------------------------------------
    // gpio
    // ------------------------------------------------------------------------
    gpio_regs #(
        .NUM_PINS       ( NUM_PINS      )
    ) i_gpio_regs (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .apb_i          ( gpio_req      ),
        .apb_o          ( gpio_rsp      ),
        .mode_o         ( gpio_mode     ),
        .data_o         ( gpio_data     ),
        .pin_sync_i     ( gpio_sync     )
    );

    gpio_pads #(
        .NUM_PINS       ( NUM_PINS      )
    ) i_gpio_pads (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .mode_i         ( gpio_mode     ),
        .data_i         ( gpio_data     ),
        .gpio_i         ( gpio_i        ),
        .gpio_o         ( gpio_o        ),
        .gpio_oe_o      ( gpio_oe_o     ),
        .pin_sync_o     ( gpio_sync     )
    );

    // timer
    timer i_timer (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .apb_i          ( timer_req     ),
        .apb_o          ( timer_rsp     ),
        .irq_o          ( irq_o         )
    );

endmodule

// ==== source/timer.sv ====
`timescale 1ns/1ps

module timer (
    input  logic                 clk,
    input  logic                 reset_i,

    input  periph_pkg::apb_req_t apb_i,
    output periph_pkg::apb_rsp_t apb_o,

    output logic                 irq_o
);
    import periph_pkg::*;

    logic        en_q;
    logic        ie_q;
    logic        pending_q;
    logic [31:0] count_q;
    logic [31:0] value_q;

    timer_reg_e  offset;
    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic        match;
    logic [31:0] rdata;

    assign offset = timer_reg_e'(apb_i.paddr[3:0]);
    assign access = apb_i.psel & apb_i.penable;
    assign wr_en  = access & apb_i.pwrite & addr_ok;

    // a compare value of zero never fires
    assign match = en_q && (value_q != '0) && (count_q == value_q);

    // ------------------------------------------------------------------------
    // apb read side
    // ------------------------------------------------------------------------
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (offset)
            TIMER_CTRL:  rdata[2:0] = {pending_q, ie_q, en_q};
            TIMER_COUNT: rdata = count_q;
            TIMER_VALUE: rdata = value_q;
            default:     addr_ok = 1'b0;
        endcase
    end

    always_comb begin
        apb_o.pready  = 1'b1;
        apb_o.prdata  = (access && !apb_i.pwrite && addr_ok) ? rdata : '0;
        apb_o.pslverr = access & ~addr_ok;
    end

    // ------------------------------------------------------------------------
    // counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (wr_en && offset == TIMER_COUNT) begin
            count_q <= apb_i.pwdata;
        end else if (match) begin
            count_q <= '0;
        end else if (en_q) begin
            count_q <= count_q + 32'd1;
        end
    end

    // ctrl, compare value and sticky pending
    always_ff @(posedge clk) begin
        if (reset_i) begin
            en_q      <= 1'b0;
            ie_q      <= 1'b0;
            pending_q <= 1'b0;
            value_q   <= '0;
        end else begin
            if (wr_en && offset == TIMER_CTRL) begin
                en_q <= apb_i.pwdata[TIMER_EN_BIT];
                ie_q <= apb_i.pwdata[TIMER_IE_BIT];
            end
            if (wr_en && offset == TIMER_VALUE) begin
                value_q <= apb_i.pwdata;
            end
            // a new hit takes priority over a clear in the same cycle
            if (match) begin
                pending_q <= 1'b1;
            end else if (wr_en && offset == TIMER_CTRL && apb_i.pwdata[TIMER_PND_BIT]) begin
                pending_q <= 1'b0;
            end
        end
    end

    assign irq_o = pending_q & ie_q;

endmodule

// ==== verif/periph_props.sv ====
`timescale 1ns/1ps

module periph_props #(
    parameter int NUM_PINS = 16
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  periph_pkg::apb_req_t apb_req_i,
    input  periph_pkg::apb_rsp_t apb_rsp_i,
    input  logic [NUM_PINS-1:0]  gpio_out_i,
    input  logic [NUM_PINS-1:0]  gpio_oe_i,
    input  logic                 irq_i
);
    import periph_pkg::*;

    logic ie_seen;
    logic ctrl_wr;

    // interrupt enable as last written over the bus
    assign ctrl_wr = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite
                     && (apb_req_i.paddr[11:8] == TIMER_BASE)
                     && (apb_req_i.paddr[3:0] == TIMER_CTRL);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ie_seen <= 1'b0;
        end else if (ctrl_wr) begin
            ie_seen <= apb_req_i.pwdata[TIMER_IE_BIT];
        end
    end

    // ------------------------------------------------------------------------
    // bus protocol
    // ------------------------------------------------------------------------
    slverr_in_access: assert property (@(posedge clk) disable iff (reset_i)
        apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable))
        else $error("pslverr raised outside an access cycle");

    // interrupt only with its enable set
    irq_needs_enable: assert property (@(posedge clk) disable iff (reset_i)
        irq_i |-> ie_seen)
        else $error("irq_o high while the interrupt enable is clear");

    // undriven pins carry no data
    pin_masked: assert property (@(posedge clk) disable iff (reset_i)
        (gpio_out_i & ~gpio_oe_i) == '0)
        else $error("gpio_o set on a pin whose output enable is low");

endmodule

bind periph_top periph_props #(
    .NUM_PINS       ( NUM_PINS          )
) i_periph_props (
    .clk            ( clk               ),
    .reset_i        ( reset_i           ),
    .apb_req_i      ( apb_i             ),
    .apb_rsp_i      ( apb_o             ),
    .gpio_out_i     ( gpio_o            ),
    .gpio_oe_i      ( gpio_oe_o         ),
    .irq_i          ( irq_o             )
);

// ==== verif/periph_tb.sv ====
`timescale 1ns/1ps

module periph_tb;
    import periph_pkg::*;

    localparam int NUM_PINS       = 16;
    localparam int PREADY_TIMEOUT = 8;

    localparam logic [11:0] ADDR_GPIO_CTRL   = {GPIO_BASE, 4'h0, GPIO_CTRL};
    localparam logic [11:0] ADDR_GPIO_DATA   = {GPIO_BASE, 4'h0, GPIO_DATA};
    localparam logic [11:0] ADDR_GPIO_IN     = {GPIO_BASE, 4'h0, GPIO_IN};
    localparam logic [11:0] ADDR_TIMER_CTRL  = {TIMER_BASE, 4'h0, TIMER_CTRL};
    localparam logic [11:0] ADDR_TIMER_COUNT = {TIMER_BASE, 4'h0, TIMER_COUNT};
    localparam logic [11:0] ADDR_TIMER_VALUE = {TIMER_BASE, 4'h0, TIMER_VALUE};

    logic                clk;
    logic                reset_i;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic [NUM_PINS-1:0] gpio_in;
    logic [NUM_PINS-1:0] gpio_out;
    logic [NUM_PINS-1:0] gpio_oe;
    logic                irq;

    integer      seed;
    // register model
    logic [31:0] ctrl_m;
    logic [31:0] data_m;
    logic [31:0] value_m;
    logic [31:0] tctrl_m;

    periph_top #(
        .NUM_PINS       ( NUM_PINS      )
    ) i_periph_top (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .apb_i          ( apb_req       ),
        .apb_o          ( apb_rsp       ),
        .gpio_i         ( gpio_in       ),
        .gpio_o         ( gpio_out      ),
        .gpio_oe_o      ( gpio_oe       ),
        .irq_o          ( irq           )
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // checking helpers
    // ------------------------------------------------------------------------
    task automatic report_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            report_failure();
        end
    endtask

    // mode 01 is the only driving mode
    function automatic logic [NUM_PINS-1:0] expected_oe(input logic [31:0] mode);
        logic [NUM_PINS-1:0] oe;
        oe = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            oe[n] = (mode[2*n +: 2] == 2'b01);
        end
        return oe;
    endfunction

    task automatic check_pins();
        logic [NUM_PINS-1:0] oe_exp;
        oe_exp = expected_oe(ctrl_m);
        check_value("gpio_oe_o", oe_exp, gpio_oe);
        check_value("gpio_o", data_m[NUM_PINS-1:0] & oe_exp, gpio_out);
    endtask

    // ------------------------------------------------------------------------
    // apb transfers
    // ------------------------------------------------------------------------
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        int wait_cnt;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        // response sampled mid-cycle
        #2;
        wait_cnt = 0;
        while (apb_rsp.pready !== 1'b1) begin
            if (wait_cnt >= PREADY_TIMEOUT) begin
                $display("timeout: pready stayed low at address %h", addr);
                report_failure();
            end
            @(posedge clk);
            #3;
            wait_cnt++;
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(1'b1, addr, wdata, rdata, slverr);
        check_value("pslverr", 32'h0, slverr);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata);
        logic slverr;
        apb_transfer(1'b0, addr, 32'h0, rdata, slverr);
        check_value("pslverr", 32'h0, slverr);
    endtask

    task automatic read_check(input logic [11:0] addr, input string name,
                              input logic [31:0] exp);
        logic [31:0] rdata;
        apb_read(addr, rdata);
        check_value(name, exp, rdata);
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] pick;
        logic [31:0] value;
        logic [11:0] addr;
        logic [3:0]  region;
        logic [3:0]  offset;
        logic        write;
        logic        err;
        int          limit;
        int          cnt;

        clk     = 1'b0;
        reset_i = 1'b1;
        apb_req = '0;
        gpio_in = '0;
        seed    = 32'h236ad934;
        ctrl_m  = '0;
        data_m  = '0;
        value_m = '0;
        tctrl_m = '0;

        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // reset state
        check_value("gpio_oe_o", 32'h0, gpio_oe);
        check_value("gpio_o", 32'h0, gpio_out);
        check_value("irq_o", 32'h0, irq);
        read_check(ADDR_GPIO_CTRL, "GPIO_CTRL", 32'h0);
        read_check(ADDR_GPIO_DATA, "GPIO_DATA", 32'h0);
        read_check(ADDR_TIMER_CTRL, "TIMER_CTRL", 32'h0);
        read_check(ADDR_TIMER_COUNT, "TIMER_COUNT", 32'h0);
        read_check(ADDR_TIMER_VALUE, "TIMER_VALUE", 32'h0);

        // gpio outputs
        for (int i = 0; i < 50; i++) begin
            pick  = $random(seed);
            wdata = $random(seed);
            if (pick[0]) begin
                apb_write(ADDR_GPIO_CTRL, wdata);
                ctrl_m = wdata;
            end else begin
                apb_write(ADDR_GPIO_DATA, wdata);
                data_m = {16'h0, wdata[15:0]};
            end
            check_pins();
            read_check(ADDR_GPIO_CTRL, "GPIO_CTRL", ctrl_m);
            read_check(ADDR_GPIO_DATA, "GPIO_DATA", data_m);
            check_pins();
        end

        // gpio inputs held 3 cycles before readback
        for (int i = 0; i < 30; i++) begin
            @(posedge clk);
            #1;
            gpio_in = $random(seed);
            repeat (3) @(posedge clk);
            read_check(ADDR_GPIO_IN, "GPIO_IN", {16'h0, gpio_in});
        end

        // ------------------------------------------------------------------------
        // timer interrupt
        // ------------------------------------------------------------------------
        value = 32'd5 + ($unsigned($random(seed)) % 32'd36);
        apb_write(ADDR_TIMER_VALUE, value);
        value_m = value;
        apb_write(ADDR_TIMER_COUNT, 32'h0);
        apb_write(ADDR_TIMER_CTRL, 32'h3);
        tctrl_m = 32'h3;
        limit = 2 * value + 10;
        cnt   = 0;
        while (irq !== 1'b1) begin
            if (cnt >= limit) begin
                $display("timeout: irq_o did not rise within %0d cycles", limit);
                report_failure();
            end
            @(posedge clk);
            #3;
            cnt++;
        end
        read_check(ADDR_TIMER_CTRL, "TIMER_CTRL", tctrl_m | 32'h4);
        // stop the count first so no new hit races the clear
        apb_write(ADDR_TIMER_CTRL, 32'h2);
        tctrl_m = 32'h2;
        apb_write(ADDR_TIMER_CTRL, 32'h6);
        check_value("irq_o", 32'h0, irq);
        read_check(ADDR_TIMER_CTRL, "TIMER_CTRL", tctrl_m);

        // pending still sets with the interrupt disabled
        apb_write(ADDR_TIMER_COUNT, 32'h0);
        apb_write(ADDR_TIMER_CTRL, 32'h1);
        tctrl_m = 32'h1;
        cnt   = 0;
        rdata = '0;
        while (rdata[2] !== 1'b1) begin
            if (cnt >= limit) begin
                $display("timeout: pending never set with the interrupt disabled");
                report_failure();
            end
            check_value("irq_o", 32'h0, irq);
            apb_read(ADDR_TIMER_CTRL, rdata);
            cnt++;
        end
        check_value("TIMER_CTRL", tctrl_m | 32'h4, rdata);
        check_value("irq_o", 32'h0, irq);
        apb_write(ADDR_TIMER_CTRL, 32'h0);
        tctrl_m = 32'h0;
        apb_write(ADDR_TIMER_CTRL, 32'h4);
        read_check(ADDR_TIMER_CTRL, "TIMER_CTRL", tctrl_m);

        // ------------------------------------------------------------------------
        // error responses
        // ------------------------------------------------------------------------
        for (int i = 0; i < 24; i++) begin
            pick   = $random(seed);
            wdata  = $random(seed);
            region = 4'h2 + (pick[5:2] % 4'd14);
            offset = pick[9:6];
            if (offset == 4'h0 || offset == 4'h4 || offset == 4'h8) begin
                offset = offset + 4'h1;
            end
            write = pick[10];
            case (pick[1:0])
                2'd0: addr = {region, 4'h0, pick[9:6]};
                2'd1: addr = {GPIO_BASE, 4'h0, offset};
                2'd2: addr = {TIMER_BASE, 4'h0, offset};
                default: begin
                    addr  = ADDR_GPIO_IN;
                    write = 1'b1;
                end
            endcase
            apb_transfer(write, addr, wdata, rdata, err);
            check_value("pslverr", 32'h1, err);
            check_value("prdata", 32'h0, rdata);
        end
        read_check(ADDR_GPIO_CTRL, "GPIO_CTRL", ctrl_m);
        read_check(ADDR_GPIO_DATA, "GPIO_DATA", data_m);
        read_check(ADDR_TIMER_VALUE, "TIMER_VALUE", value_m);
        read_check(ADDR_TIMER_CTRL, "TIMER_CTRL", tctrl_m);
        check_pins();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
